//--- Makefile
# Verilator build and run of the character layer testbench

TOP = tb_char_layer
LOG = sim.log

.PHONY: all run lint clean

all: run

# Build, run, then look for the pass line in the log
run:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

lint:
	verilator --lint-only --timing -Wall -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

//--- sim/tb_char_layer.sv
// Top of the character layer simulation with a tile table, ROM model and per-pixel colour checks
module tb_char_layer import tile_pkg::*; ();

    localparam int CLK_PERIOD  = 20;
    localparam int DRV         = 2;
    localparam int NUM_ENTRIES = 8;
    localparam int CYCLE_LIMIT = NUM_ENTRIES * (H_TOTAL * V_TOTAL * 2 + 1000);

    // Columns are tile col, tile row, code, attribute, palette seed (0 for none) and ROM stall
    // Attribute bits from the top are vflip, hflip, code msb and a 5-bit palette
    localparam logic [30:0] STIM [NUM_ENTRIES] = '{
        {5'd3,  5'd4,  8'h11, 8'h03, 4'h9, 1'b0},
        {5'd10, 5'd6,  8'h22, 8'h45, 4'h2, 1'b0},
        {5'd17, 5'd9,  8'h33, 8'h87, 4'h6, 1'b0},
        {5'd31, 5'd29, 8'h44, 8'he9, 4'h0, 1'b0},
        {5'd0,  5'd2,  8'h55, 8'h2a, 4'hc, 1'b0},
        {5'd12, 5'd15, 8'h66, 8'h0b, 4'h3, 1'b1},
        {5'd13, 5'd15, 8'h77, 8'h0c, 4'h0, 1'b0},
        {5'd20, 5'd20, 8'h11, 8'h23, 4'h5, 1'b0}
    };

    logic        clk;
    logic        rst = 1'b1;
    logic [10:0] cpu_addr;
    logic [7:0]  cpu_din;
    logic        cpu_we;
    logic        cpu_cs;
    logic [7:0]  cpu_dout;
    logic        rom_valid;
    logic [11:0] rom_addr;
    logic        rom_ready;
    logic [15:0] rom_data;
    logic        prog_en;
    logic [7:0]  prog_addr;
    logic [3:0]  prog_data;
    logic [8:0]  hcount;
    logic [8:0]  vcount;
    logic        lblank_n;
    logic        vblank_n;
    logic [3:0]  colour;

    // Model of the map banks, the palette and the stalled ROM tag
    logic [7:0]  attr_model [TILE_COLS*TILE_ROWS];
    logic [7:0]  code_model [TILE_COLS*TILE_ROWS];
    logic [3:0]  pal_model [256];
    logic        stall_on = 1'b0;
    logic [8:0]  stall_tag = '0;
    logic        check_on = 1'b0;
    logic [31:0] lfsr = 32'h62c;
    int          pixel_errs = 0;
    int          cpu_errs = 0;
    int          rom_errs = 0;
    int          timing_errs = 0;

    char_layer i_char_layer (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Galois step for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // Pattern word scrambled from the full address
    function automatic logic [15:0] rom_word(input logic [11:0] addr);
        logic [15:0] w;
        w = {addr, addr[11:8]};
        return (w * 16'd40503) ^ 16'h5a5a;
    endfunction

    // Start-up palette with entry 0 black
    function automatic logic [3:0] fill_colour(input logic [7:0] a);
        return a[3:0] + (a[7:4] * 4'd3);
    endfunction

    // Colour of screen pixel (x, y) from the models
    function automatic logic [3:0] expected_colour(input int x, input int y);
        int          idx;
        int          i;
        int          b;
        logic [7:0]  a;
        logic [2:0]  r;
        logic [11:0] addr;
        logic [15:0] rd;
        logic [1:0]  pv;
        if (x >= H_VISIBLE || y < V_VIS_START || y >= V_VIS_END) begin
            return 4'd0;
        end
        idx = (y / 8) * TILE_COLS + x / 8;
        a   = attr_model[idx];
        r   = 3'(y % 8);
        // Vertical flip walks the rows bottom up
        if (a[ATTR_VFLIP]) begin
            r = 3'd7 - r;
        end
        addr = {a[ATTR_CODE_MSB], code_model[idx], r};
        i    = a[ATTR_HFLIP] ? 7 - x % 8 : x % 8;
        if (stall_on && addr[11:3] == stall_tag) begin
            pv = 2'd0;
        end else begin
            // Each byte holds four pixels with plane 1 in the low nibble, plane 0 in the high
            rd = rom_word(addr);
            b  = (i < 4) ? i : i + 4;
            pv = {rd[b], rd[b + 4]};
        end
        return pal_model[{1'b0, a[ATTR_PAL_LSB +: 5], pv}];
    endfunction

    task automatic cpu_write(input logic [10:0] addr, input logic [7:0] data);
        cpu_addr = addr;
        cpu_din  = data;
        cpu_cs   = 1'b1;
        cpu_we   = 1'b1;
        if (addr[BANK_BIT]) begin
            code_model[addr[9:0]] = data;
        end else begin
            attr_model[addr[9:0]] = data;
        end
        @(posedge clk);
        #DRV;
        cpu_cs = 1'b0;
        cpu_we = 1'b0;
    endtask

    task automatic cpu_read_check(input logic [10:0] addr, input logic [7:0] exp_val);
        cpu_addr = addr;
        cpu_cs   = 1'b1;
        cpu_we   = 1'b0;
        @(posedge clk);
        #DRV;
        assert (cpu_dout == exp_val) else begin
            cpu_errs++;
            $display("ERR %0t cpu_dout at %h exp %h got %h", $time, addr, exp_val, cpu_dout);
        end
        cpu_cs = 1'b0;
    endtask

    task automatic write_palette(input logic [7:0] addr, input logic [3:0] data);
        prog_en        = 1'b1;
        prog_addr      = addr;
        prog_data      = data;
        pal_model[addr] = data;
        @(posedge clk);
        #DRV;
        prog_en = 1'b0;
    endtask

    // Writes a tile into the map with bank readbacks and an optional palette reload
    task automatic apply_entry(input logic [30:0] ent);
        logic [9:0] idx;
        logic [7:0] code;
        logic [7:0] attr;
        idx  = 10'(ent[25:21] * TILE_COLS + ent[30:26]);
        code = ent[20:13];
        attr = ent[12:5];
        cpu_write({1'b0, idx}, attr);
        // Code byte at the same index must be untouched
        cpu_read_check({1'b1, idx}, code_model[idx]);
        cpu_write({1'b1, idx}, code);
        cpu_read_check({1'b0, idx}, attr);
        cpu_read_check({1'b1, idx}, code);
        if (ent[4:1] != 4'd0) begin
            for (int i = 0; i < 4; i++) begin
                write_palette({1'b0, attr[4:0], 2'(i)}, ent[4:1] + 4'(i * 5));
            end
        end
        stall_on  = ent[0];
        stall_tag = {attr[ATTR_CODE_MSB], code};
    endtask

    task automatic wait_frame_start();
        do begin
            @(posedge clk);
            #DRV;
        end while (!(hcount == 9'd0 && vcount == 9'd0));
    endtask

    // Pattern ROM model answering after 0..7 clocks and never for the stalled tag
    initial begin : rom_model
        logic        pending;
        logic [11:0] req_addr;
        int          wait_left;
        pending   = 1'b0;
        req_addr  = '0;
        wait_left = 0;
        rom_ready = 1'b0;
        rom_data  = '0;
        forever begin
            @(posedge clk);
            #DRV;
            if (rom_ready || !rom_valid) begin
                // Transfer taken or request dropped
                rom_ready = 1'b0;
                pending   = 1'b0;
            end else begin
                if (!pending) begin
                    pending   = 1'b1;
                    req_addr  = rom_addr;
                    wait_left = 0;
                    for (int k = 0; k < 3; k++) begin
                        lfsr      = lfsr_step(lfsr);
                        wait_left = wait_left * 2 + int'(lfsr[0]);
                    end
                end
                assert (rom_addr == req_addr) else begin
                    rom_errs++;
                    $display("ERR %0t rom_addr exp %h got %h", $time, req_addr, rom_addr);
                end
                if (!(stall_on && req_addr[11:3] == stall_tag)) begin
                    if (wait_left == 0) begin
                        rom_ready = 1'b1;
                        rom_data  = rom_word(req_addr);
                    end else begin
                        wait_left--;
                    end
                end
            end
        end
    end

    // Beam position model compared with the DUT on each pixel tick
    initial begin : monitor
        logic exp_cen;
        int   exp_h;
        int   exp_v;
        logic [3:0] exp_col;
        exp_cen = 1'b0;
        exp_h   = 0;
        exp_v   = 0;
        @(negedge rst);
        forever begin
            @(negedge clk);
            assert (i_char_layer.pxl_cen == exp_cen) else begin
                timing_errs++;
                $display("ERR %0t pxl_cen exp %b got %b", $time, exp_cen, i_char_layer.pxl_cen);
            end
            if (exp_cen) begin
                assert (hcount == exp_h && vcount == exp_v) else begin
                    timing_errs++;
                    $display("ERR %0t hcount/vcount exp %0d/%0d got %0d/%0d", $time,
                             exp_h, exp_v, hcount, vcount);
                end
                assert (lblank_n == (exp_h < H_VISIBLE)) else begin
                    timing_errs++;
                    $display("ERR %0t lblank_n exp %b got %b", $time,
                             exp_h < H_VISIBLE, lblank_n);
                end
                assert (vblank_n == (exp_v >= V_VIS_START && exp_v < V_VIS_END)) else begin
                    timing_errs++;
                    $display("ERR %0t vblank_n exp %b got %b", $time,
                             exp_v >= V_VIS_START && exp_v < V_VIS_END, vblank_n);
                end
                if (check_on) begin
                    exp_col = expected_colour(exp_h, exp_v);
                    assert (colour == exp_col) else begin
                        pixel_errs++;
                        $display("ERR %0t colour at (%0d,%0d) exp %h got %h", $time,
                                 exp_h, exp_v, exp_col, colour);
                    end
                end
                exp_h++;
                if (exp_h == H_TOTAL) begin
                    exp_h = 0;
                    exp_v = (exp_v + 1) % V_TOTAL;
                end
            end
            exp_cen = !exp_cen;
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: frame loop still running after %0d cycles", CYCLE_LIMIT);
        $display("Test failed");
        $finish;
    end

    initial begin : stimulus
        cpu_addr  = '0;
        cpu_din   = '0;
        cpu_we    = 1'b0;
        cpu_cs    = 1'b0;
        prog_en   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        repeat (5) @(posedge clk);
        #DRV;
        rst = 1'b0;
        // Blank map and full palette loaded within the top blanking lines
        for (int a = 0; a < 2048; a++) begin
            cpu_write(11'(a), 8'h00);
        end
        for (int a = 0; a < 256; a++) begin
            write_palette(8'(a), fill_colour(8'(a)));
        end
        check_on = 1'b1;
        // One entry per frame while the monitor checks every pixel
        for (int n = 0; n < NUM_ENTRIES; n++) begin
            apply_entry(STIM[n]);
            wait_frame_start();
        end
        $display("Errors: pixel %0d, cpu %0d, rom %0d, timing %0d",
                 pixel_errs, cpu_errs, rom_errs, timing_errs);
        if (pixel_errs + cpu_errs + rom_errs + timing_errs == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- source/char_layer.sv
// Character layer top: timing, tile RAM, tile fetch, pixel shifter and palette wired together
module char_layer import tile_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    // CPU port
    input  logic [10:0]       cpu_addr,
    input  logic [7:0]        cpu_din,
    input  logic              cpu_we,
    input  logic              cpu_cs,
    output logic [7:0]        cpu_dout,
    // Pattern ROM port
    output logic              rom_valid,
    output logic [ROM_AW-1:0] rom_addr,
    input  logic              rom_ready,
    input  logic [15:0]       rom_data,
    // Palette load
    input  logic              prog_en,
    input  logic [7:0]        prog_addr,
    input  logic [3:0]        prog_data,
    // Video out
    output logic [8:0]        hcount,
    output logic [8:0]        vcount,
    output logic              lblank_n,
    output logic              vblank_n,
    output logic [3:0]        colour
);

    logic        pxl_cen;
    logic [9:0]  map_addr;
    logic [7:0]  attr;
    logic [7:0]  code;
    logic        tile_load;
    logic [15:0] row_data;
    logic        row_hflip;
    logic [4:0]  row_pal;
    logic        row_ok;
    logic [7:0]  pal_index;

    video_timer i_video_timer (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .hcount   (hcount),
        .vcount   (vcount),
        .lblank_n (lblank_n),
        .vblank_n (vblank_n)
    );

    tile_ram i_tile_ram (
        .clk      (clk),
        .cpu_addr (cpu_addr),
        .cpu_din  (cpu_din),
        .cpu_we   (cpu_we),
        .cpu_cs   (cpu_cs),
        .cpu_dout (cpu_dout),
        .map_addr (map_addr),
        .attr     (attr),
        .code     (code)
    );

    // Works H_PREFETCH pixels ahead of the beam
    tile_fetch_fsm i_tile_fetch_fsm (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .hcount    (hcount),
        .vcount    (vcount),
        .map_addr  (map_addr),
        .attr      (attr),
        .code      (code),
        .rom_valid (rom_valid),
        .rom_addr  (rom_addr),
        .rom_ready (rom_ready),
        .rom_data  (rom_data),
        .tile_load (tile_load),
        .row_data  (row_data),
        .row_hflip (row_hflip),
        .row_pal   (row_pal),
        .row_ok    (row_ok)
    );

    tile_shifter i_tile_shifter (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .tile_load (tile_load),
        .row_data  (row_data),
        .row_hflip (row_hflip),
        .row_pal   (row_pal),
        .row_ok    (row_ok),
        .lblank_n  (lblank_n),
        .pal_index (pal_index)
    );

    palette_prom i_palette_prom (
        .clk       (clk),
        .pxl_cen   (pxl_cen),
        .prog_en   (prog_en),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .pal_index (pal_index),
        .colour    (colour)
    );

endmodule

//--- source/palette_prom.sv
// Colour lookup PROM: 256 entries of 4 bits, loaded over the prog port, read on each pixel tick
module palette_prom (
    input  logic       clk,
    input  logic       pxl_cen,
    input  logic       prog_en,
    input  logic [7:0] prog_addr,
    input  logic [3:0] prog_data,
    input  logic [7:0] pal_index,
    output logic [3:0] colour
);

    // Entry 0 is the backdrop colour shown in blanking
    logic [3:0] pal_mem [256];

    // One entry per clock while loading
    always_ff @(posedge clk) begin
        if (prog_en) begin
            pal_mem[prog_addr] <= prog_data;
        end
    end

    // Output register, one pixel tick of delay
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            colour <= pal_mem[pal_index];
        end
    end

endmodule

//--- source/tile_fetch_fsm.sv
// Tile fetch FSM: reads the map ahead of the beam and fetches one pattern row per tile over valid/ready
module tile_fetch_fsm import tile_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              pxl_cen,
    input  logic [8:0]        hcount,
    input  logic [8:0]        vcount,
    output logic [9:0]        map_addr,
    input  logic [7:0]        attr,
    input  logic [7:0]        code,
    output logic              rom_valid,
    output logic [ROM_AW-1:0] rom_addr,
    input  logic              rom_ready,
    input  logic [15:0]       rom_data,
    output logic              tile_load,
    output logic [15:0]       row_data,
    output logic              row_hflip,
    output logic [4:0]        row_pal,
    output logic              row_ok
);

    logic [8:0] pre_sum;
    logic       pre_wrap;
    logic [8:0] pre_x;
    logic [8:0] pre_line;
    logic       tile_vis;
    logic       boundary;
    logic [1:0] state;
    logic [2:0] row_q;

    // Prefetch position, wrapping into the next line near the end of blanking
    assign pre_sum  = hcount + 9'(H_PREFETCH);
    assign pre_wrap = pre_sum >= 9'(H_TOTAL);
    assign pre_x    = pre_wrap ? pre_sum - 9'(H_TOTAL) : pre_sum;
    assign pre_line = pre_wrap ? vcount + 9'd1 : vcount;

    // Is the fetched tile on screen at all
    assign tile_vis = (pre_x < 9'(H_VISIBLE)) && (pre_line >= 9'(V_VIS_START))
                    && (pre_line < 9'(V_VIS_END));

    // Tile slot starts every 8 pixel ticks
    assign boundary  = pxl_cen && (pre_x[2:0] == 3'd0);
    assign tile_load = boundary;

    // Map row and column, held at zero off screen
    assign map_addr = tile_vis ? {pre_line[7:3], pre_x[7:3]} : '0;

    // Control path
    // A boundary always restarts, so a late ROM answer is dropped
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            rom_valid <= 1'b0;
            row_ok    <= 1'b0;
            row_pal   <= '0;
            row_hflip <= 1'b0;
        end else if (boundary) begin
            rom_valid <= 1'b0;
            row_ok    <= 1'b0;
            if (tile_vis) begin
                state <= ST_MAP_WAIT;
            end else begin
                // Blank tile shows index 0
                state     <= ST_IDLE;
                row_pal   <= '0;
                row_hflip <= 1'b0;
            end
        end else begin
            case (state)
                ST_MAP_WAIT: begin
                    row_pal   <= attr[ATTR_PAL_LSB +: 5];
                    row_hflip <= attr[ATTR_HFLIP];
                    rom_valid <= 1'b1;
                    state     <= ST_REQUEST;
                end
                ST_REQUEST: begin
                    if (rom_ready) begin
                        rom_valid <= 1'b0;
                        row_ok    <= 1'b1;
                        state     <= ST_HOLD;
                    end
                end
                default: begin
                    // IDLE and HOLD wait for the next slot
                    state <= state;
                end
            endcase
        end
    end

    // Data path
    always_ff @(posedge clk) begin
        if (boundary) begin
            row_q <= pre_line[2:0];
        end
        // Code msb, code, row with vertical flip
        if (!boundary && state == ST_MAP_WAIT) begin
            rom_addr <= {attr[ATTR_CODE_MSB], code, row_q ^ {3{attr[ATTR_VFLIP]}}};
        end
        if (!boundary && state == ST_REQUEST && rom_ready) begin
            row_data <= rom_data;
        end
    end

    // Address held while the ROM stalls
    a_rom_addr_stable: assert property (
        @(posedge clk) disable iff (rst)
        rom_valid && !rom_ready |=> $stable(rom_addr)
    );

endmodule

//--- source/tile_pkg.sv
// Shared video timing, tile map layout, attribute bits and fetch FSM codes, imported by the RTL
package tile_pkg;

    // Pixel ticks per line and the visible part at its start
    localparam int H_TOTAL   = 320;
    localparam int H_VISIBLE = 256;

    // Lines per frame and the visible window
    localparam int V_TOTAL     = 264;
    localparam int V_VIS_START = 16;
    localparam int V_VIS_END   = 240;

    // Tile map, 32x32 tiles of 8x8 pixels
    localparam int TILE_COLS = 32;
    localparam int TILE_ROWS = 32;

    // CPU address bit choosing attribute (0) or code (1) bank
    localparam int BANK_BIT = 10;

    // Fetch lead in pixels
    // One tile slot for the ROM fetch, plus one tick each for shifter and palette registers
    localparam int H_PREFETCH = 10;

    // Attribute byte layout, palette field is bits 4..0
    localparam int ATTR_VFLIP    = 7;
    localparam int ATTR_HFLIP    = 6;
    localparam int ATTR_CODE_MSB = 5;
    localparam int ATTR_PAL_LSB  = 0;

    // Pattern ROM address: code msb, code, row
    localparam int ROM_AW = 12;

    // Tile fetch FSM state codes
    localparam logic [1:0] ST_IDLE     = 2'd0;
    localparam logic [1:0] ST_MAP_WAIT = 2'd1;
    localparam logic [1:0] ST_REQUEST  = 2'd2;
    localparam logic [1:0] ST_HOLD     = 2'd3;

endpackage

//--- source/tile_ram.sv
// Tile map RAM: attribute and code banks, CPU read/write port plus video read port for the fetch
module tile_ram import tile_pkg::*; (
    input  logic        clk,
    input  logic [10:0] cpu_addr,
    input  logic [7:0]  cpu_din,
    input  logic        cpu_we,
    input  logic        cpu_cs,
    output logic [7:0]  cpu_dout,
    input  logic [9:0]  map_addr,
    output logic [7:0]  attr,
    output logic [7:0]  code
);

    // One byte per map cell in each bank
    logic [7:0] attr_mem [TILE_COLS*TILE_ROWS];
    logic [7:0] code_mem [TILE_COLS*TILE_ROWS];

    logic [BANK_BIT-1:0] cpu_index;
    logic                wr_attr;
    logic                wr_code;
    logic [7:0]          cpu_attr_q;
    logic [7:0]          cpu_code_q;
    logic                bank_q;

    assign cpu_index = cpu_addr[BANK_BIT-1:0];

    // Bank bit steers the write
    assign wr_attr = cpu_cs && cpu_we && !cpu_addr[BANK_BIT];
    assign wr_code = cpu_cs && cpu_we &&  cpu_addr[BANK_BIT];

    // Attribute bank
    // Reads return the old byte on a same-address write
    always_ff @(posedge clk) begin
        if (wr_attr) begin
            attr_mem[cpu_index] <= cpu_din;
        end
        cpu_attr_q <= attr_mem[cpu_index];
        attr       <= attr_mem[map_addr];
    end

    // Code bank, same structure
    always_ff @(posedge clk) begin
        if (wr_code) begin
            code_mem[cpu_index] <= cpu_din;
        end
        cpu_code_q <= code_mem[cpu_index];
        code       <= code_mem[map_addr];
    end

    // Bank select follows the data by one clock
    always_ff @(posedge clk) begin
        bank_q <= cpu_addr[BANK_BIT];
    end

    assign cpu_dout = bank_q ? cpu_code_q : cpu_attr_q;

endmodule

//--- source/tile_shifter.sv
// Pixel shifter: splits a pattern row into two bitplanes and builds the palette index per pixel
module tile_shifter (
    input  logic        clk,
    input  logic        rst,
    input  logic        pxl_cen,
    input  logic        tile_load,
    input  logic [15:0] row_data,
    input  logic        row_hflip,
    input  logic [4:0]  row_pal,
    input  logic        row_ok,
    input  logic        lblank_n,
    output logic [7:0]  pal_index
);

    logic [15:0] pix_q;
    logic [4:0]  pal_q;
    logic        flip_q;
    logic        fresh_q;
    logic [15:0] planes;
    logic [1:0]  pix;

    // Low byte holds plane 0, high byte plane 1
    // ROM nibbles arrive interleaved per half tile
    assign planes = {row_data[11:8], row_data[3:0], row_data[15:12], row_data[7:4]};

    // Load at the slot start, shift on the other ticks
    always_ff @(posedge clk) begin
        if (rst) begin
            pix_q   <= '0;
            pal_q   <= '0;
            flip_q  <= 1'b0;
            fresh_q <= 1'b0;
        end else if (pxl_cen) begin
            fresh_q <= tile_load;
            if (tile_load) begin
                // Missed ROM answer leaves pixel value 0
                pix_q  <= row_ok ? planes : '0;
                pal_q  <= row_pal;
                flip_q <= row_hflip;
            end else if (flip_q) begin
                pix_q <= pix_q << 1;
            end else begin
                pix_q <= pix_q >> 1;
            end
        end
    end

    // Mirrored rows read from the top of each plane
    assign pix = flip_q ? {pix_q[15], pix_q[7]} : {pix_q[8], pix_q[0]};

    // The index leads the beam by one tick
    // a fresh load in blanking is already the next line's first pixel
    assign pal_index = (!lblank_n && !fresh_q) ? 8'd0 : {1'b0, pal_q, pix};

    // Loads only come on pixel ticks
    a_load_on_cen: assert property (
        @(posedge clk) disable iff (rst)
        tile_load |-> pxl_cen
    );

endmodule

//--- source/video_timer.sv
// Beam timing for the tile layer, giving pixel enable, counters and blanking to the top level
module video_timer import tile_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    output logic       pxl_cen,
    output logic [8:0] hcount,
    output logic [8:0] vcount,
    output logic       lblank_n,
    output logic       vblank_n
);

    logic line_end;
    logic frame_end;

    // Last tick of the line and last line of the frame
    assign line_end  = hcount == 9'(H_TOTAL - 1);
    assign frame_end = vcount == 9'(V_TOTAL - 1);

    // Divide by two
    // Low on the first clock after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            pxl_cen <= 1'b0;
        end else begin
            pxl_cen <= ~pxl_cen;
        end
    end

    // Horizontal counter, one step per pixel tick
    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
        end else if (pxl_cen) begin
            if (line_end) begin
                hcount <= '0;
            end else begin
                hcount <= hcount + 9'd1;
            end
        end
    end

    // Vertical counter steps at the horizontal wrap
    always_ff @(posedge clk) begin
        if (rst) begin
            vcount <= '0;
        end else if (pxl_cen && line_end) begin
            if (frame_end) begin
                vcount <= '0;
            end else begin
                vcount <= vcount + 9'd1;
            end
        end
    end

    // Blanking decoded straight from the counts
    // so it changes on the same edge as the counters
    assign lblank_n = hcount < 9'(H_VISIBLE);
    assign vblank_n = (vcount >= 9'(V_VIS_START)) && (vcount < 9'(V_VIS_END));

    // Counters never leave their ranges
    a_count_range: assert property (
        @(posedge clk) disable iff (rst)
        (hcount < 9'(H_TOTAL)) && (vcount < 9'(V_TOTAL))
    );

endmodule

//--- verilog.f
source/tile_pkg.sv
source/video_timer.sv
source/tile_ram.sv
source/tile_fetch_fsm.sv
source/tile_shifter.sv
source/palette_prom.sv
source/char_layer.sv
sim/tb_char_layer.sv
